/* verilog/sam_asic_macros.svh */
//====================
// Shared constants for the cut-down SAM Coupe ASIC.
// Included by the packages and RTL that need port numbers or timing.
//====================

`ifndef SAM_ASIC_MACROS_SVH
`define SAM_ASIC_MACROS_SVH

// Physical memory map
`define SAM_RAM_ADDR_BITS 20
`define SAM_ROM_BASE      20'h80000

// ASIC port numbers, low address byte
`define SAM_PORT_LPTD 8'd232
`define SAM_PORT_LPTS 8'd233
`define SAM_PORT_STAT 8'd249
`define SAM_PORT_LMPR 8'd250
`define SAM_PORT_HMPR 8'd251
`define SAM_PORT_MIDI 8'd253
`define SAM_PORT_BRDR 8'd254

// MIDI timing, clk_sys cycles per 1 MHz tick and ticks per frame
`define SAM_MIDI_DIV    48
`define SAM_MIDI_FRAME  319
`define SAM_MIDI_INT_AT 15

`endif

/* verilog/sam_mem_pkg.sv */
//====================
// Bus and memory types shared by the port block, pager, arbiter and top.
// Import with a wildcard in the module header.
//====================

`default_nettype none

`include "sam_asic_macros.svh"

package sam_mem_pkg;

	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0] byte_t;
	typedef logic [`SAM_RAM_ADDR_BITS-1:0] phys_addr_t;

	// 16 KB page number
	typedef logic [4:0] page_t;

	// Paging state decoded from LMPR and HMPR
	typedef struct packed {
		page_t lmpr_page;
		logic  rom0_off;
		logic  rom1_on;
		logic  write_prot;
		page_t hmpr_page;
	} mem_page_cfg_t;

endpackage

`default_nettype wire

/* verilog/sam_audio_pkg.sv */
//====================
// Audio sample types for the DAC latch and mixer.
//====================

`default_nettype none

package sam_audio_pkg;

	// Unsigned mixed sample
	typedef logic [18:0] sample_t;

	// Printer port DAC level
	typedef logic [7:0] vox_t;

endpackage

`default_nettype wire

/* verilog/sam_mem_if.sv */
//====================
// One memory request channel between the pager and the RAM arbiter.
// req holds until grant; grant is a single cycle.
//====================

`timescale 1ns/10ps
`default_nettype none

interface sam_mem_if
	import sam_mem_pkg::*;
();

	logic       req;
	logic       we;
	phys_addr_t addr;
	byte_t      wdata;
	byte_t      rdata;
	logic       grant;

	// Requester side
	modport master (output req, we, addr, wdata, input rdata, grant);

	// Memory side
	modport slave (input req, we, addr, wdata, output rdata, grant);

endinterface

`default_nettype wire

/* verilog/sam_io_ports.sv */
//====================
// ASIC port decode: LMPR, HMPR and border registers, port strobes
// for the printer DAC and MIDI, and the I/O read multiplexer.
//====================

`timescale 1ns/10ps
`default_nettype none

`include "sam_asic_macros.svh"

module sam_io_ports
	import sam_mem_pkg::*;
(
	input  logic          clk_sys,
	input  logic          reset,
	input  cpu_addr_t     cpu_addr,
	input  byte_t         cpu_wdata,
	input  logic          n_iorq,
	input  logic          n_rd,
	input  logic          n_wr,
	input  logic          n_m1,
	input  logic          midi_int,
	output mem_page_cfg_t page_cfg,
	output logic          ear,
	output logic [3:0]    border_color,
	output byte_t         io_rdata,
	output logic          io_sel,
	output logic          lptd_strobe,
	output logic          lpts_strobe,
	output logic          midi_start
);

	byte_t lmpr;
	byte_t hmpr;
	byte_t port_num;
	logic  port_we;
	logic  port_we_d;
	logic  port_wr_stb;

	assign port_num = cpu_addr[7:0];

	// Port write, ignoring interrupt acknowledge cycles
	assign port_we     = ~n_iorq & ~n_wr & n_m1;
	assign port_wr_stb = port_we & ~port_we_d;
	assign io_sel      = ~n_iorq & ~n_rd & n_m1;

	//====================
	// Registers
	//====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			port_we_d    <= 1'b0;
			lmpr         <= '0;
			hmpr         <= '0;
			border_color <= '0;
			ear          <= 1'b0;
		end else begin
			port_we_d <= port_we;
			if (port_wr_stb) begin
				if (port_num == `SAM_PORT_LMPR) lmpr <= cpu_wdata;
				if (port_num == `SAM_PORT_HMPR) hmpr <= cpu_wdata;
				if (port_num == `SAM_PORT_BRDR) begin
					// Colour is bit 5 over bits 2..0
					border_color <= {cpu_wdata[5], cpu_wdata[2:0]};
					ear          <= cpu_wdata[4];
				end
			end
		end
	end

	assign lptd_strobe = port_wr_stb & (port_num == `SAM_PORT_LPTD);
	assign lpts_strobe = port_wr_stb & (port_num == `SAM_PORT_LPTS);
	assign midi_start  = port_wr_stb & (port_num == `SAM_PORT_MIDI);

	assign page_cfg.lmpr_page  = lmpr[4:0];
	assign page_cfg.rom0_off   = lmpr[5];
	assign page_cfg.rom1_on    = lmpr[6];
	assign page_cfg.write_prot = lmpr[7];
	assign page_cfg.hmpr_page  = hmpr[4:0];

	//====================
	// Read mux
	//====================
	always_comb begin
		case (port_num)
			`SAM_PORT_LMPR: io_rdata = lmpr;
			`SAM_PORT_HMPR: io_rdata = hmpr;
			// Status, MIDI interrupt active low on bit 4
			`SAM_PORT_STAT: io_rdata = {3'b111, ~midi_int, 4'b1111};
			`SAM_PORT_LPTD, `SAM_PORT_LPTS: io_rdata = 8'h00;
			default:        io_rdata = 8'hFF;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/sam_mem_pager.sv */
//====================
// Maps the CPU address onto the physical RAM/ROM space and raises
// one request per memory cycle on the master side of sam_mem_if.
//====================

`timescale 1ns/10ps
`default_nettype none

`include "sam_asic_macros.svh"

module sam_mem_pager
	import sam_mem_pkg::*;
(
	input  logic          clk_sys,
	input  logic          reset,
	input  cpu_addr_t     cpu_addr,
	input  byte_t         cpu_wdata,
	input  logic          n_mreq,
	input  logic          n_rd,
	input  logic          n_wr,
	input  mem_page_cfg_t page_cfg,
	sam_mem_if.master     mem
);

	localparam phys_addr_t ROM0_BASE = `SAM_ROM_BASE;
	localparam phys_addr_t ROM1_BASE = ROM0_BASE + phys_addr_t'(20'h04000);

	logic [1:0] section;
	logic       rom0_sel;
	logic       rom1_sel;
	logic       wr_prot;
	logic       mem_acc;
	logic       mem_acc_d;
	page_t      page;
	phys_addr_t phys_addr;

	assign section  = cpu_addr[15:14];
	assign rom0_sel = ~page_cfg.rom0_off & (section == 2'd0);
	assign rom1_sel = page_cfg.rom1_on & (section == 2'd3);
	assign wr_prot  = page_cfg.write_prot & (section == 2'd0);
	assign mem_acc  = ~n_mreq & (~n_rd | ~n_wr);

	// Odd sections take the next page up
	always_comb begin
		page = section[1] ? page_cfg.hmpr_page : page_cfg.lmpr_page;
		if (section[0])
			page = page + 5'd1;
		if (rom0_sel)
			phys_addr = ROM0_BASE + phys_addr_t'(cpu_addr[13:0]);
		else if (rom1_sel)
			phys_addr = ROM1_BASE + phys_addr_t'(cpu_addr[13:0]);
		else
			phys_addr = {1'b0, page, cpu_addr[13:0]};
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mem_acc_d <= 1'b0;
			mem.req   <= 1'b0;
		end else begin
			mem_acc_d <= mem_acc;
			if (mem.grant)
				mem.req <= 1'b0;
			if (mem_acc & ~mem_acc_d)
				mem.req <= 1'b1;
		end
	end

	// Request payload, captured at the start of the memory cycle
	always_ff @(posedge clk_sys) begin
		if (mem_acc & ~mem_acc_d) begin
			mem.addr  <= phys_addr;
			mem.wdata <= cpu_wdata;
			mem.we    <= ~n_wr & ~(rom0_sel | rom1_sel | wr_prot);
		end
	end

	// A pending request keeps its payload until the grant
	a_req_held: assert property (@(posedge clk_sys) disable iff (reset)
		mem.req && !mem.grant |=> mem.req && $stable(mem.addr) && $stable(mem.we));

endmodule

`default_nettype wire

/* verilog/sam_mem_arbiter.sv */
//====================
// Shared byte RAM with two peers. The boot loader has fixed priority;
// the CPU channel is granted in the first cycle the loader is idle.
//====================

`timescale 1ns/10ps
`default_nettype none

`include "sam_asic_macros.svh"

module sam_mem_arbiter
	import sam_mem_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       load_wr,
	input  phys_addr_t load_addr,
	input  byte_t      load_data,
	sam_mem_if.slave   cpu,
	output logic       mem_wait
);

	localparam int RAM_DEPTH = 1 << `SAM_RAM_ADDR_BITS;

	byte_t ram [RAM_DEPTH];

	// Loader wins any cycle it writes in
	assign cpu.grant = cpu.req & ~load_wr;
	assign mem_wait  = cpu.req & ~cpu.grant;

	//====================
	// RAM port
	//====================
	always_ff @(posedge clk_sys) begin
		if (load_wr)
			ram[load_addr] <= load_data;
		else if (cpu.grant & cpu.we)
			ram[cpu.addr] <= cpu.wdata;
	end

	// Read data stays put until the next grant
	always_ff @(posedge clk_sys) begin
		if (cpu.grant)
			cpu.rdata <= ram[cpu.addr];
	end

	// Pager must drop the request right after its grant
	a_grant_single: assert property (@(posedge clk_sys) disable iff (reset)
		cpu.grant |-> !load_wr ##1 !cpu.grant);

endmodule

`default_nettype wire

/* verilog/sam_midi_tx.sv */
//====================
// MIDI output timer. A write to the MIDI port marks a byte pending;
// the frame starts on the next idle 1 MHz tick.
//====================

`timescale 1ns/10ps
`default_nettype none

`include "sam_asic_macros.svh"

module sam_midi_tx (
	input  logic clk_sys,
	input  logic reset,
	input  logic midi_start,
	output logic midi_tx,
	output logic midi_int
);

	localparam int DIV   = `SAM_MIDI_DIV;
	localparam int DIV_W = $clog2(DIV);

	logic [DIV_W-1:0] div_cnt;
	logic [8:0]       tx_time;
	logic             tick;
	logic             pending;

	assign tick = (div_cnt == '0);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div_cnt  <= '0;
			tx_time  <= '0;
			pending  <= 1'b0;
			midi_tx  <= 1'b0;
			midi_int <= 1'b0;
		end else begin
			div_cnt <= (div_cnt == DIV_W'(DIV - 1)) ? '0 : div_cnt + 1'b1;
			if (tick) begin
				if (tx_time != '0) begin
					tx_time <= tx_time - 9'd1;
					if (tx_time == 9'(`SAM_MIDI_INT_AT))
						midi_int <= 1'b1;
				end else begin
					midi_int <= 1'b0;
					midi_tx  <= pending;
					if (pending) begin
						tx_time <= 9'(`SAM_MIDI_FRAME);
						pending <= 1'b0;
					end
				end
			end
			// New byte may arrive during a frame
			if (midi_start)
				pending <= 1'b1;
		end
	end

	a_int_in_frame: assert property (@(posedge clk_sys) disable iff (reset)
		midi_int |-> midi_tx);

endmodule

`default_nettype wire

/* verilog/sam_audio_mixer.sv */
//====================
// Printer port DAC: port 232 latches a byte, edges of bit 0 on port 233
// move it into the left or right level. Mixed with the beeper bit.
//====================

`timescale 1ns/10ps
`default_nettype none

module sam_audio_mixer
	import sam_audio_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic [7:0] cpu_wdata,
	input  logic       lptd_strobe,
	input  logic       lpts_strobe,
	input  logic       ear,
	output sample_t    audio_l,
	output sample_t    audio_r
);

	vox_t lpt_data;
	vox_t vox_l;
	vox_t vox_r;
	logic stb_d;

	always_ff @(posedge clk_sys) begin
		if (lptd_strobe)
			lpt_data <= cpu_wdata;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vox_l <= '0;
			vox_r <= '0;
			stb_d <= 1'b0;
		end else if (lpts_strobe) begin
			// Rising bit 0 loads left, falling loads right
			if (~stb_d & cpu_wdata[0])
				vox_l <= lpt_data;
			if (stb_d & ~cpu_wdata[0])
				vox_r <= lpt_data;
			stb_d <= cpu_wdata[0];
		end
	end

	// Level times 1028 plus ear times 65536
	assign audio_l = {1'b0, vox_l, vox_l, 2'b00} + {2'b00, ear, 16'h0000};
	assign audio_r = {1'b0, vox_r, vox_r, 2'b00} + {2'b00, ear, 16'h0000};

endmodule

`default_nettype wire

/* verilog/sam_asic_top.sv */
//====================
// Top of the ASIC glue block. Z80 bus, loader port and outputs
// are plain ports; the blocks inside share one memory channel.
//====================

`timescale 1ns/10ps
`default_nettype none

module sam_asic_top
	import sam_mem_pkg::*, sam_audio_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	// Z80 bus
	input  cpu_addr_t  cpu_addr,
	input  byte_t      cpu_wdata,
	input  logic       n_mreq,
	input  logic       n_iorq,
	input  logic       n_rd,
	input  logic       n_wr,
	input  logic       n_m1,
	output byte_t      cpu_rdata,
	output logic       mem_wait,
	// Boot image loader
	input  logic       load_wr,
	input  phys_addr_t load_addr,
	input  byte_t      load_data,
	output logic [3:0] border_color,
	output logic       midi_tx,
	output logic       midi_int,
	output sample_t    audio_l,
	output sample_t    audio_r
);

	mem_page_cfg_t page_cfg;
	byte_t         io_rdata;
	logic          io_sel;
	logic          ear;
	logic          lptd_strobe;
	logic          lpts_strobe;
	logic          midi_start;

	sam_mem_if cpu_mem ();

	sam_io_ports u_io_ports (
		.clk_sys(clk_sys), .reset(reset),
		.cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
		.n_iorq(n_iorq), .n_rd(n_rd), .n_wr(n_wr), .n_m1(n_m1),
		.midi_int(midi_int), .page_cfg(page_cfg), .ear(ear),
		.border_color(border_color), .io_rdata(io_rdata), .io_sel(io_sel),
		.lptd_strobe(lptd_strobe), .lpts_strobe(lpts_strobe),
		.midi_start(midi_start)
	);

	sam_mem_pager u_mem_pager (
		.clk_sys(clk_sys), .reset(reset),
		.cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
		.n_mreq(n_mreq), .n_rd(n_rd), .n_wr(n_wr),
		.page_cfg(page_cfg), .mem(cpu_mem.master)
	);

	sam_mem_arbiter u_mem_arbiter (
		.clk_sys(clk_sys), .reset(reset),
		.load_wr(load_wr), .load_addr(load_addr), .load_data(load_data),
		.cpu(cpu_mem.slave), .mem_wait(mem_wait)
	);

	sam_midi_tx u_midi_tx (
		.clk_sys(clk_sys), .reset(reset), .midi_start(midi_start),
		.midi_tx(midi_tx), .midi_int(midi_int)
	);

	sam_audio_mixer u_audio_mixer (
		.clk_sys(clk_sys), .reset(reset), .cpu_wdata(cpu_wdata),
		.lptd_strobe(lptd_strobe), .lpts_strobe(lpts_strobe), .ear(ear),
		.audio_l(audio_l), .audio_r(audio_r)
	);

	// CPU read data source
	always_comb begin
		if (~n_mreq & ~n_rd)
			cpu_rdata = cpu_mem.rdata;
		else if (io_sel)
			cpu_rdata = io_rdata;
		else
			cpu_rdata = 8'hFF;
	end

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
//====================
// Clock and reset source for the testbench.
// 10 ns period, reset held high for the first 10 cycles.
//====================

`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
	parameter int HALF_PERIOD  = 5,
	parameter int RESET_CYCLES = 10
) (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #(HALF_PERIOD) clk_sys = ~clk_sys;
	end

	// Release on a falling edge, away from the DUT's sampling edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

/* tb/tb_sam_asic.sv */
//====================
// Testbench for the SAM Coupe ASIC glue block. Drives the Z80 bus and
// the loader on the falling edge; concurrent assertions check results.
//====================

`timescale 1ns/10ps
`default_nettype none

`include "sam_asic_macros.svh"

module tb_sam_asic;

	localparam int WAIT_LIMIT = 64;
	localparam int DIV        = `SAM_MIDI_DIV;

	logic        clk_sys;
	logic        reset;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_wdata;
	logic        n_mreq;
	logic        n_iorq;
	logic        n_rd;
	logic        n_wr;
	logic        n_m1;
	logic [7:0]  cpu_rdata;
	logic        mem_wait;
	logic        load_wr;
	logic [19:0] load_addr;
	logic [7:0]  load_data;
	logic [3:0]  border_color;
	logic        midi_tx;
	logic        midi_int;
	logic [18:0] audio_l;
	logic [18:0] audio_r;

	// Compare channel, checked on the rising edge
	logic        cmp_valid = 1'b0;
	logic [31:0] cmp_exp;
	logic [31:0] cmp_act;
	string       cmp_name;

	string       test_name;
	int          value_errs = 0;
	int          midi_errs = 0;
	int          wait_errs = 0;
	int          timeout_errs = 0;
	int          tests_run = 0;
	int          test_start_errs;
	logic        aborted = 1'b0;

	// Boot image bytes, reused by the protection test
	logic [7:0]  rom_bytes [8];
	logic [7:0]  ram_bytes [8];

	tb_clock u_clock (.clk_sys(clk_sys), .reset(reset));

	sam_asic_top u_sam_asic_top (
		.clk_sys(clk_sys), .reset(reset),
		.cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
		.n_mreq(n_mreq), .n_iorq(n_iorq), .n_rd(n_rd), .n_wr(n_wr), .n_m1(n_m1),
		.cpu_rdata(cpu_rdata), .mem_wait(mem_wait),
		.load_wr(load_wr), .load_addr(load_addr), .load_data(load_data),
		.border_color(border_color), .midi_tx(midi_tx), .midi_int(midi_int),
		.audio_l(audio_l), .audio_r(audio_r)
	);

	//====================
	// Checkers
	//====================
	a_value_match: assert property (@(posedge clk_sys) cmp_valid |-> cmp_act == cmp_exp)
	else begin
		$display("Error: test %s, %s: expected %0h, actual %0h",
			test_name, cmp_name, cmp_exp, cmp_act);
		value_errs = value_errs + 1;
	end

	a_midi_framed: assert property (@(posedge clk_sys) disable iff (reset)
		midi_int |-> midi_tx)
	else begin
		$display("Test %s: midi_int is high outside a MIDI frame", test_name);
		midi_errs = midi_errs + 1;
	end

	a_wait_in_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		mem_wait |-> !n_mreq)
	else begin
		$display("Test %s: mem_wait is high with no CPU memory cycle", test_name);
		wait_errs = wait_errs + 1;
	end

	//====================
	// Helpers
	//====================
	function automatic int total_errors();
		return value_errs + midi_errs + wait_errs + timeout_errs;
	endfunction

	// 16 KB per page
	function automatic logic [19:0] page_addr(input int page, input int offset);
		return 20'(page * 32'h4000 + offset);
	endfunction

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		cmp_name  = name;
		cmp_exp   = expected;
		cmp_act   = actual;
		cmp_valid = 1'b1;
		@(posedge clk_sys);
		@(negedge clk_sys);
		cmp_valid = 1'b0;
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout in test %s: no %s", test_name, what);
		timeout_errs = timeout_errs + 1;
		aborted      = 1'b1;
	endtask

	task automatic start_test(input string name);
		test_name       = name;
		test_start_errs = total_errors();
	endtask

	task automatic finish_test();
		int errs;
		errs      = total_errors() - test_start_errs;
		tests_run = tests_run + 1;
		if (errs == 0)
			$display("test %s: ok", test_name);
		else
			$display("test %s: %0d error(s)", test_name, errs);
	endtask

	task automatic load_byte(input logic [19:0] addr, input logic [7:0] data);
		@(negedge clk_sys);
		load_wr   = 1'b1;
		load_addr = addr;
		load_data = data;
		@(negedge clk_sys);
		load_wr = 1'b0;
	endtask

	// One port write per bus cycle, held for two clocks
	task automatic write_port(input logic [7:0] port, input logic [7:0] data);
		@(negedge clk_sys);
		cpu_addr  = {8'h00, port};
		cpu_wdata = data;
		n_iorq    = 1'b0;
		n_wr      = 1'b0;
		repeat (2) @(negedge clk_sys);
		n_iorq = 1'b1;
		n_wr   = 1'b1;
	endtask

	task automatic read_port(input logic [7:0] port, output logic [7:0] data);
		@(negedge clk_sys);
		cpu_addr = {8'h00, port};
		n_iorq   = 1'b0;
		n_rd     = 1'b0;
		@(negedge clk_sys);
		data   = cpu_rdata;
		n_iorq = 1'b1;
		n_rd   = 1'b1;
	endtask

	// Request rises a cycle after MREQ, then waits out the loader
	task automatic wait_grant();
		int n;
		n = 0;
		@(negedge clk_sys);
		while (mem_wait && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n = n + 1;
		end
		if (mem_wait)
			report_timeout("memory grant");
		@(negedge clk_sys);
	endtask

	task automatic write_mem(input logic [15:0] addr, input logic [7:0] data);
		@(negedge clk_sys);
		cpu_addr  = addr;
		cpu_wdata = data;
		n_mreq    = 1'b0;
		n_wr      = 1'b0;
		wait_grant();
		n_mreq = 1'b1;
		n_wr   = 1'b1;
	endtask

	task automatic read_mem(input logic [15:0] addr, output logic [7:0] data);
		@(negedge clk_sys);
		cpu_addr = addr;
		n_mreq   = 1'b0;
		n_rd     = 1'b0;
		wait_grant();
		data   = cpu_rdata;
		n_mreq = 1'b1;
		n_rd   = 1'b1;
	endtask

	//====================
	// Tests
	//====================
	task automatic test_rom_paging();
		logic [7:0] rd;
		start_test("rom_paging");
		compare("mem_wait after reset", 0, 32'(mem_wait));
		compare("midi_tx after reset", 0, 32'(midi_tx));
		compare("audio_l after reset", 0, 32'(audio_l));
		for (int i = 0; i < 8; i++) begin
			rom_bytes[i] = 8'($urandom);
			ram_bytes[i] = 8'($urandom);
			load_byte(`SAM_ROM_BASE + 20'(i), rom_bytes[i]);
			load_byte(page_addr(0, i), ram_bytes[i]);
		end
		for (int i = 0; i < 8; i++) begin
			read_mem(16'(i), rd);
			compare("rom0 read", {24'h0, rom_bytes[i]}, 32'(rd));
		end
		// ROM0 off, section A on RAM page 0
		write_port(`SAM_PORT_LMPR, 8'h20);
		for (int i = 0; i < 8; i++) begin
			read_mem(16'(i), rd);
			compare("ram page 0 read", {24'h0, ram_bytes[i]}, 32'(rd));
		end
		finish_test();
	endtask

	task automatic test_page_map();
		logic [7:0] c_data [4];
		logic [7:0] d_data [4];
		logic [7:0] rd;
		int         p;
		int         q;
		start_test("page_map");
		p = 2 + int'($urandom % 12);
		q = p + 16;
		for (int i = 0; i < 4; i++) begin
			c_data[i] = 8'($urandom);
			d_data[i] = 8'($urandom);
			// The other page holds the complement
			load_byte(page_addr(q, i), ~c_data[i]);
			load_byte(page_addr(q + 1, i), ~d_data[i]);
		end
		write_port(`SAM_PORT_HMPR, 8'(p));
		for (int i = 0; i < 4; i++) begin
			write_mem(16'h8000 + 16'(i), c_data[i]);
			write_mem(16'hC000 + 16'(i), d_data[i]);
		end
		write_port(`SAM_PORT_HMPR, 8'(q));
		for (int i = 0; i < 4; i++) begin
			read_mem(16'h8000 + 16'(i), rd);
			compare("section C other page", {24'h0, ~c_data[i]}, 32'(rd));
			read_mem(16'hC000 + 16'(i), rd);
			compare("section D other page", {24'h0, ~d_data[i]}, 32'(rd));
		end
		write_port(`SAM_PORT_HMPR, 8'(p));
		for (int i = 0; i < 4; i++) begin
			read_mem(16'h8000 + 16'(i), rd);
			compare("section C readback", {24'h0, c_data[i]}, 32'(rd));
			read_mem(16'hC000 + 16'(i), rd);
			compare("section D readback", {24'h0, d_data[i]}, 32'(rd));
		end
		finish_test();
	endtask

	task automatic test_protection();
		logic [7:0] rd;
		logic [7:0] rom1_byte;
		logic       wait_held;
		start_test("protection");
		rom1_byte = 8'($urandom);
		load_byte(`SAM_ROM_BASE + 20'h04000, rom1_byte);
		// Section A on page 0, write protected
		write_port(`SAM_PORT_LMPR, 8'hA0);
		for (int i = 0; i < 2; i++) begin
			write_mem(16'(i), ~ram_bytes[i]);
			read_mem(16'(i), rd);
			compare("protected write", {24'h0, ram_bytes[i]}, 32'(rd));
		end
		// ROM0 and ROM1 both paged in
		write_port(`SAM_PORT_LMPR, 8'h40);
		write_mem(16'h0001, ~rom_bytes[1]);
		read_mem(16'h0001, rd);
		compare("rom0 write", {24'h0, rom_bytes[1]}, 32'(rd));
		write_mem(16'hC000, ~rom1_byte);
		read_mem(16'hC000, rd);
		compare("rom1 write", {24'h0, rom1_byte}, 32'(rd));
		// Loader stream into page 31 against a CPU read
		wait_held = 1'b1;
		fork
			begin
				for (int i = 0; i < 10; i++) begin
					@(negedge clk_sys);
					if (i > 0 && !mem_wait)
						wait_held = 1'b0;
					load_wr   = 1'b1;
					load_addr = page_addr(31, i);
					load_data = 8'($urandom);
				end
				@(negedge clk_sys);
				if (!mem_wait)
					wait_held = 1'b0;
				load_wr = 1'b0;
			end
			read_mem(16'h0002, rd);
		join
		compare("mem_wait held during stream", 1, 32'(wait_held));
		compare("mem_wait cleared", 0, 32'(mem_wait));
		compare("read after stream", {24'h0, rom_bytes[2]}, 32'(rd));
		finish_test();
	endtask

	task automatic test_port_reads();
		logic [7:0] lmpr_val;
		logic [7:0] hmpr_val;
		logic [7:0] brdr_val;
		logic [7:0] rd;
		start_test("port_reads");
		lmpr_val = 8'($urandom);
		hmpr_val = 8'($urandom);
		brdr_val = 8'($urandom);
		write_port(`SAM_PORT_LMPR, lmpr_val);
		read_port(`SAM_PORT_LMPR, rd);
		compare("lmpr readback", {24'h0, lmpr_val}, 32'(rd));
		write_port(`SAM_PORT_HMPR, hmpr_val);
		read_port(`SAM_PORT_HMPR, rd);
		compare("hmpr readback", {24'h0, hmpr_val}, 32'(rd));
		read_port(8'd16, rd);
		compare("unknown port", 32'hFF, 32'(rd));
		read_port(`SAM_PORT_LPTD, rd);
		compare("printer data port", 0, 32'(rd));
		write_port(`SAM_PORT_BRDR, brdr_val);
		compare("border colour", {28'h0, brdr_val[5], brdr_val[2:0]}, 32'(border_color));
		finish_test();
	endtask

	task automatic test_midi();
		logic [7:0] rd;
		int         n;
		start_test("midi");
		write_port(`SAM_PORT_MIDI, 8'($urandom));
		n = 0;
		while (!midi_tx && n < 4 * DIV) begin
			@(negedge clk_sys);
			n = n + 1;
		end
		if (!midi_tx)
			report_timeout("midi_tx rise after the port write");
		n = 0;
		while (!midi_int && n < (`SAM_MIDI_FRAME + 4) * DIV) begin
			@(negedge clk_sys);
			n = n + 1;
		end
		if (!midi_int)
			report_timeout("MIDI interrupt");
		compare("midi_tx during interrupt", 1, 32'(midi_tx));
		// Bit 4 of the status port is the interrupt, active low
		read_port(`SAM_PORT_STAT, rd);
		compare("status during interrupt", 32'hEF, 32'(rd));
		n = 0;
		while ((midi_int || midi_tx) && n < (`SAM_MIDI_INT_AT + 4) * DIV) begin
			@(negedge clk_sys);
			n = n + 1;
		end
		if (midi_int || midi_tx)
			report_timeout("end of the MIDI frame");
		read_port(`SAM_PORT_STAT, rd);
		compare("status after frame", 32'hFF, 32'(rd));
		finish_test();
	endtask

	task automatic test_vox();
		logic [7:0] left;
		logic [7:0] right;
		logic       ear_bit;
		int         exp_l;
		int         exp_r;
		start_test("vox_mix");
		left    = 8'($urandom);
		right   = 8'($urandom);
		// Beeper on, so the mix carries the ear term
		ear_bit = 1'b1;
		// Level times 1028, beeper worth 65536
		exp_l = int'(left) * 1028 + (ear_bit ? 65536 : 0);
		exp_r = int'(right) * 1028 + (ear_bit ? 65536 : 0);
		write_port(`SAM_PORT_BRDR, {3'b000, ear_bit, 4'h0});
		write_port(`SAM_PORT_LPTD, left);
		write_port(`SAM_PORT_LPTS, 8'h01);
		write_port(`SAM_PORT_LPTD, right);
		write_port(`SAM_PORT_LPTS, 8'h00);
		compare("audio_l", 32'(exp_l), 32'(audio_l));
		compare("audio_r", 32'(exp_r), 32'(audio_r));
		finish_test();
	endtask

	//====================
	// Sequence
	//====================
	initial begin
		int n;
		void'($urandom(32'h6c8c944e));
		cpu_addr  = '0;
		cpu_wdata = '0;
		n_mreq    = 1'b1;
		n_iorq    = 1'b1;
		n_rd      = 1'b1;
		n_wr      = 1'b1;
		n_m1      = 1'b1;
		load_wr   = 1'b0;
		load_addr = '0;
		load_data = '0;
		test_name = "reset";
		n = 0;
		while (reset && n < 100) begin
			@(negedge clk_sys);
			n = n + 1;
		end
		if (reset)
			report_timeout("release of reset");
		if (!aborted)
			test_rom_paging();
		if (!aborted)
			test_page_map();
		if (!aborted)
			test_protection();
		if (!aborted)
			test_port_reads();
		if (!aborted)
			test_midi();
		if (!aborted)
			test_vox();
		$display("%0d tests run, %0d errors", tests_run, total_errors());
		if (total_errors() == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* sam_asic.f */
+incdir+verilog
verilog/sam_mem_pkg.sv
verilog/sam_audio_pkg.sv
verilog/sam_mem_if.sv
verilog/sam_io_ports.sv
verilog/sam_mem_pager.sv
verilog/sam_mem_arbiter.sv
verilog/sam_midi_tx.sv
verilog/sam_audio_mixer.sv
verilog/sam_asic_top.sv
tb/tb_clock.sv
tb/tb_sam_asic.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the SAM ASIC testbench with Verilator and runs it.
# Exits non-zero when the build, the run or any check fails.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_sam_asic -f sam_asic.f \
	--Mdir "$BUILD_DIR" -o tb_sam_asic
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/tb_sam_asic" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
	exit 1
fi
if ! grep -q "RESULT: PASS" "$LOG"; then
	echo "No result line found in $LOG"
	exit 1
fi
exit 0
